// File: rtl/bridge_settings.sv
// settings registers written by the host over the bridge
// packs the dip word for the core and serves the read-back mux

`timescale 1ns/1ns
`default_nettype none

module bridge_settings (
    input  wire                     clk_74a,
    input  wire                     arst_n,
    input  core_pkg::bridge_addr_t  bridge_addr,
    input  wire                     bridge_wr,
    input  core_pkg::bridge_data_t  bridge_wr_data,
    output core_pkg::bridge_data_t  bridge_rd_data,
    output core_pkg::dipsw_t        core_dipsw,
    output logic                    adapter_ena,
    output logic                    reset_toggle
);
    import core_pkg::*;

    lives_t      lives;
    difficulty_t difficulty;
    bonus_t      bonus;
    logic        demo_sounds;

    // write decode, exact address match
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            lives        <= '0;
            difficulty   <= '0;
            bonus        <= '0;
            demo_sounds  <= 1'b0;
            adapter_ena  <= 1'b0;
            reset_toggle <= 1'b0;
        end else if (bridge_wr) begin
            case (bridge_addr)
                ADDR_LIVES:        lives        <= bridge_wr_data[1:0];
                ADDR_DIFFICULTY:   difficulty   <= bridge_wr_data[2:0];
                ADDR_BONUS:        bonus        <= bridge_wr_data[2:0];
                ADDR_DEMO_SOUNDS:  demo_sounds  <= bridge_wr_data[0];
                ADDR_ADAPTER_ENA:  adapter_ena  <= bridge_wr_data[0];
                // data ignored, any write flips it
                ADDR_RESET_TOGGLE: reset_toggle <= ~reset_toggle;
                default: ;
            endcase
        end
    end

    // high byte: difficulty over bonus
    // low byte: demo sounds at top, lives at 5:4
    assign core_dipsw = {2'b00, difficulty, bonus, demo_sounds, 1'b0, lives, 4'b0000};

    // read-back, only the adapter enable is visible
    always_comb begin
        case (bridge_addr)
            ADDR_ADAPTER_ENA: bridge_rd_data = {31'b0, adapter_ena};
            default:          bridge_rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/coin_pulse.sv
// stretches a coin button release into a long pulse for the core
// edges that land during a pulse are dropped

`timescale 1ns/1ns
`default_nettype none

module coin_pulse (
    input  wire  clk_74a,
    input  wire  arst_n,
    input  wire  coin_key,
    output logic coin
);
    import controls_pkg::*;

    logic                  key_q;
    logic                  key_qq;
    logic [COIN_CNT_W-1:0] pulse_cnt;

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            key_q     <= 1'b0;
            key_qq    <= 1'b0;
            pulse_cnt <= '0;
        end else begin
            key_q  <= coin_key;
            key_qq <= key_q;
            if (pulse_cnt != '0)
                pulse_cnt <= pulse_cnt - 1'b1;
            // release of the button
            else if (key_qq && !key_q)
                pulse_cnt <= COIN_CNT_W'(COIN_PULSE_CYCLES);
        end
    end

    assign coin = (pulse_cnt != '0);

endmodule

`default_nettype wire

// File: rtl/control_router.sv
// routes host pads or adapter pads onto the two core players
// analog adapters get their d-pad from stick thresholds

`timescale 1ns/1ns
`default_nettype none

module control_router (
    input  wire                 clk_74a,
    input  wire                 arst_n,
    snac_if.sink                snac,
    input  wire                 adapter_ena,
    input  controls_pkg::keys_t cont1_key,
    input  controls_pkg::keys_t cont2_key,
    output controls_pkg::keys_t player_1,
    output controls_pkg::keys_t player_2
);
    import controls_pkg::*;

    // left stick only, y in 15:8, x in 7:0
    function automatic logic [3:0] stick_dpad(input joy_t joy);
        logic [3:0] d;
        d[KEY_UP]    = joy[15:8] < STICK_LOW;
        d[KEY_DOWN]  = joy[15:8] > STICK_HIGH;
        d[KEY_LEFT]  = joy[7:0] < STICK_LOW;
        d[KEY_RIGHT] = joy[7:0] > STICK_HIGH;
        return d;
    endfunction

    // adapter buttons with the d-pad bits swapped in
    function automatic keys_t with_dpad(input keys_t btn, input logic [3:0] d);
        return {btn[15:4], d};
    endfunction

    logic       is_analog;
    logic       use_snac;
    assign_t    assign_q;
    keys_t      cont1_q;
    keys_t      cont2_q;
    keys_t      p1_btn_q;
    keys_t      p2_btn_q;
    logic [3:0] p1_dpad;
    logic [3:0] p2_dpad;

    assign is_analog = (snac.cont_type == CONT_ANALOG_A) || (snac.cont_type == CONT_ANALOG_B);

    //////////////////////////////////////////////////////////////////////
    // stage one
    //////////////////////////////////////////////////////////////////////

    // everything goes through here so both paths see two cycles
    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            use_snac <= 1'b0;
            assign_q <= '0;
            cont1_q  <= '0;
            cont2_q  <= '0;
            p1_btn_q <= '0;
            p2_btn_q <= '0;
            p1_dpad  <= '0;
            p2_dpad  <= '0;
        end else begin
            use_snac <= adapter_ena && (snac.cont_type != CONT_NONE);
            assign_q <= snac.assignment;
            cont1_q  <= cont1_key;
            cont2_q  <= cont2_key;
            p1_btn_q <= snac.p1_btn;
            p2_btn_q <= snac.p2_btn;
            p1_dpad  <= is_analog ? stick_dpad(snac.p1_joy) : snac.p1_btn[3:0];
            p2_dpad  <= is_analog ? stick_dpad(snac.p2_joy) : snac.p2_btn[3:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage two
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            player_1 <= '0;
            player_2 <= '0;
        end else if (!use_snac) begin
            player_1 <= cont1_q;
            player_2 <= cont2_q;
        end else begin
            case (assign_q)
                2'd0: begin
                    player_1 <= with_dpad(p1_btn_q, p1_dpad);
                    player_2 <= cont1_q;
                end
                // adapter 1 passed raw to player 2
                2'd1: begin
                    player_1 <= cont1_q;
                    player_2 <= p1_btn_q;
                end
                2'd2: begin
                    player_1 <= with_dpad(p1_btn_q, p1_dpad);
                    player_2 <= with_dpad(p2_btn_q, p2_dpad);
                end
                default: begin
                    player_1 <= with_dpad(p2_btn_q, p2_dpad);
                    player_2 <= with_dpad(p1_btn_q, p1_dpad);
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/controls_pkg.sv
// shared definitions for the controller path
// pad key positions, stick thresholds, adapter types and coin pulse length

`default_nettype none

package controls_pkg;

    typedef logic [15:0] keys_t;
    typedef logic [31:0] joy_t;

    // key bitmap positions of the host pads
    localparam int KEY_UP     = 0;
    localparam int KEY_DOWN   = 1;
    localparam int KEY_LEFT   = 2;
    localparam int KEY_RIGHT  = 3;
    localparam int KEY_A      = 4;
    localparam int KEY_SELECT = 14;
    localparam int KEY_START  = 15;

    // stick idles near 0x7f, so these leave a wide dead zone
    localparam logic [7:0] STICK_LOW  = 8'h40;
    localparam logic [7:0] STICK_HIGH = 8'hC0;

    // adapter controller types
    typedef logic [4:0] cont_type_t;
    localparam cont_type_t CONT_NONE     = 5'h00;
    localparam cont_type_t CONT_ANALOG_A = 5'h12;
    localparam cont_type_t CONT_ANALOG_B = 5'h13;

    typedef logic [1:0] assign_t;

    // up, down, left, right, fire, start, coin
    typedef logic [6:0] core_ctrl_t;

    localparam int COIN_PULSE_CYCLES = 32;
    localparam int COIN_CNT_W        = 6;

endpackage

`default_nettype wire

// File: rtl/core_pkg.sv
// shared definitions for the core side of the shell
// bridge address map, DIP fields, video colour words and reset hold length
// imported by the settings, reset and video blocks

`default_nettype none

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // bridge bus
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // write addresses, exact match
    localparam bridge_addr_t ADDR_LIVES        = 32'h2000_0000;
    localparam bridge_addr_t ADDR_DIFFICULTY   = 32'h3000_0000;
    localparam bridge_addr_t ADDR_BONUS        = 32'h4000_0000;
    localparam bridge_addr_t ADDR_DEMO_SOUNDS  = 32'h5000_0000;
    localparam bridge_addr_t ADDR_ADAPTER_ENA  = 32'hF200_0000;
    localparam bridge_addr_t ADDR_RESET_TOGGLE = 32'h8000_0000;

    // dip switch fields
    typedef logic [1:0]  lives_t;
    typedef logic [2:0]  difficulty_t;
    typedef logic [2:0]  bonus_t;
    typedef logic [15:0] dipsw_t;

    // video
    typedef logic [11:0] rgb12_t;
    typedef logic [23:0] rgb24_t;

    // manual reset, short enough for simulation
    localparam int RESET_HOLD_CYCLES = 64;
    localparam int RESET_CNT_W       = 7;

endpackage

`default_nettype wire

// File: rtl/reset_stretch.sv
// turns each flip of the bridge reset toggle into a fixed-length core reset
// toggles seen while the reset is active are dropped

`timescale 1ns/1ns
`default_nettype none

module reset_stretch (
    input  wire  clk_74a,
    input  wire  arst_n,
    input  wire  reset_toggle,
    output logic core_reset
);
    import core_pkg::*;

    logic                   last_toggle;
    logic [RESET_CNT_W-1:0] hold_cnt;

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            last_toggle <= 1'b0;
            hold_cnt    <= '0;
            core_reset  <= 1'b0;
        end else begin
            // always track, so a flip during the hold is absorbed
            last_toggle <= reset_toggle;
            if (!core_reset && (reset_toggle != last_toggle)) begin
                core_reset <= 1'b1;
                hold_cnt   <= RESET_CNT_W'(RESET_HOLD_CYCLES - 1);
            end else if (core_reset) begin
                if (hold_cnt == '0)
                    core_reset <= 1'b0;
                else
                    hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/snac_if.sv
// adapter controller state as seen by the router
// levels only, driven from the top-level ports

`timescale 1ns/1ns
`default_nettype none

interface snac_if;
    import controls_pkg::*;

    keys_t      p1_btn;
    keys_t      p2_btn;
    joy_t       p1_joy;
    joy_t       p2_joy;
    cont_type_t cont_type;
    assign_t    assignment;

    modport source (output p1_btn, p2_btn, p1_joy, p2_joy, cont_type, assignment);
    modport sink   (input  p1_btn, p2_btn, p1_joy, p2_joy, cont_type, assignment);

endinterface

`default_nettype wire

// File: rtl/starforce_shell.sv
// glue between the host bridge, pads, adapter and the arcade core
// all logic runs on clk_74a; the adapter status comes in as plain inputs

`timescale 1ns/1ns
`default_nettype none

module starforce_shell (
    input  wire                         clk_74a,
    input  wire                         arst_n,
    // bridge
    input  core_pkg::bridge_addr_t      bridge_addr,
    input  wire                         bridge_wr,
    input  core_pkg::bridge_data_t      bridge_wr_data,
    output core_pkg::bridge_data_t      bridge_rd_data,
    // host pads
    input  controls_pkg::keys_t         cont1_key,
    input  controls_pkg::keys_t         cont2_key,
    // adapter state
    input  controls_pkg::keys_t         snac_p1_btn,
    input  controls_pkg::keys_t         snac_p2_btn,
    input  controls_pkg::joy_t          snac_p1_joy,
    input  controls_pkg::joy_t          snac_p2_joy,
    input  controls_pkg::cont_type_t    snac_cont_type,
    input  controls_pkg::assign_t       snac_assignment,
    input  wire                         snac_blank_screen,
    // core video
    input  core_pkg::rgb12_t            core_rgb,
    input  wire                         core_hblank,
    input  wire                         core_vblank,
    input  wire                         core_hs,
    input  wire                         core_vs,
    // scaler video
    output core_pkg::rgb24_t            video_rgb,
    output logic                        video_de,
    output logic                        video_hs,
    output logic                        video_vs,
    // to the core
    output controls_pkg::core_ctrl_t    core_controls,
    output controls_pkg::keys_t         player_2,
    output core_pkg::dipsw_t            core_dipsw,
    output logic                        core_reset
);
    import controls_pkg::*;

    logic  adapter_ena;
    logic  reset_toggle;
    logic  coin;
    keys_t player_1;

    snac_if snac_bus ();

    assign snac_bus.p1_btn     = snac_p1_btn;
    assign snac_bus.p2_btn     = snac_p2_btn;
    assign snac_bus.p1_joy     = snac_p1_joy;
    assign snac_bus.p2_joy     = snac_p2_joy;
    assign snac_bus.cont_type  = snac_cont_type;
    assign snac_bus.assignment = snac_assignment;

    bridge_settings bridge_settings_inst (
        .clk_74a        (clk_74a),
        .arst_n         (arst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .core_dipsw     (core_dipsw),
        .adapter_ena    (adapter_ena),
        .reset_toggle   (reset_toggle)
    );

    reset_stretch reset_stretch_inst (
        .clk_74a      (clk_74a),
        .arst_n       (arst_n),
        .reset_toggle (reset_toggle),
        .core_reset   (core_reset)
    );

    control_router control_router_inst (
        .clk_74a     (clk_74a),
        .arst_n      (arst_n),
        .snac        (snac_bus.sink),
        .adapter_ena (adapter_ena),
        .cont1_key   (cont1_key),
        .cont2_key   (cont2_key),
        .player_1    (player_1),
        .player_2    (player_2)
    );

    // coin follows the routed player 1 select key
    coin_pulse coin_pulse_inst (
        .clk_74a  (clk_74a),
        .arst_n   (arst_n),
        .coin_key (player_1[KEY_SELECT]),
        .coin     (coin)
    );

    video_formatter video_formatter_inst (
        .clk_74a      (clk_74a),
        .arst_n       (arst_n),
        .core_rgb     (core_rgb),
        .core_hblank  (core_hblank),
        .core_vblank  (core_vblank),
        .core_hs      (core_hs),
        .core_vs      (core_vs),
        .blank_screen (snac_blank_screen),
        .adapter_ena  (adapter_ena),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs)
    );

    // core order, msb first: up down left right fire start coin
    assign core_controls = {player_1[KEY_UP], player_1[KEY_DOWN], player_1[KEY_LEFT],
                            player_1[KEY_RIGHT], player_1[KEY_A], player_1[KEY_START], coin};

endmodule

`default_nettype wire

// File: rtl/video_formatter.sv
// formats core video for the scaler
// 4-bit colour doubled to 8 bits, blanking and one-cycle sync pulses

`timescale 1ns/1ns
`default_nettype none

module video_formatter (
    input  wire                clk_74a,
    input  wire                arst_n,
    input  core_pkg::rgb12_t   core_rgb,
    input  wire                core_hblank,
    input  wire                core_vblank,
    input  wire                core_hs,
    input  wire                core_vs,
    input  wire                blank_screen,
    input  wire                adapter_ena,
    output core_pkg::rgb24_t   video_rgb,
    output logic               video_de,
    output logic               video_hs,
    output logic               video_vs
);
    import core_pkg::*;

    rgb12_t rgb_src;
    logic   hs_prev;
    logic   vs_prev;

    // handheld screen goes black while the adapter drives a display
    assign rgb_src = (blank_screen && adapter_ena) ? '0 : core_rgb;

    always_ff @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
        end else begin
            if (core_hblank || core_vblank) begin
                video_rgb <= '0;
                video_de  <= 1'b0;
            end else begin
                video_rgb <= {{2{rgb_src[11:8]}}, {2{rgb_src[7:4]}}, {2{rgb_src[3:0]}}};
                video_de  <= 1'b1;
            end
            // scaler wants a single-cycle sync
            video_hs <= core_hs && !hs_prev;
            video_vs <= core_vs && !vs_prev;
            hs_prev  <= core_hs;
            vs_prev  <= core_vs;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
verilator --binary --timing -Wno-fatal --top-module tb_starforce_shell \
    -f starforce_shell.f -o tb_starforce_shell \
    && ./obj_dir/tb_starforce_shell > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

// File: starforce_shell.f
rtl/core_pkg.sv
rtl/controls_pkg.sv
rtl/snac_if.sv
rtl/bridge_settings.sv
rtl/reset_stretch.sv
rtl/control_router.sv
rtl/coin_pulse.sv
rtl/video_formatter.sv
rtl/starforce_shell.sv
verification/tb_starforce_shell.sv

// File: verification/tb_starforce_shell.sv
// testbench for the arcade shell
// drives bridge, pads, adapter and core video at the falling edge and compares
// the outputs against reference models at the next falling edge
// built from the file list with the run script

`timescale 1ns/1ns
`default_nettype none

module tb_starforce_shell;
    import core_pkg::*;
    import controls_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int CTRL_CYCLES     = 400;
    localparam int VIDEO_CYCLES    = 300;
    // rough sum of every test section below
    localparam int TEST_CYCLES     = 4 + 30 + (RESET_HOLD_CYCLES + 20) + (CTRL_CYCLES + 20)
                                     + (2 * COIN_PULSE_CYCLES + 30) + (VIDEO_CYCLES + 20);
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

    logic         clk_74a = 1'b0;
    logic         arst_n;
    bridge_addr_t bridge_addr;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    bridge_data_t bridge_rd_data;
    keys_t        cont1_key;
    keys_t        cont2_key;
    keys_t        snac_p1_btn;
    keys_t        snac_p2_btn;
    joy_t         snac_p1_joy;
    joy_t         snac_p2_joy;
    cont_type_t   snac_cont_type;
    assign_t      snac_assignment;
    logic         snac_blank_screen;
    rgb12_t       core_rgb;
    logic         core_hblank;
    logic         core_vblank;
    logic         core_hs;
    logic         core_vs;
    rgb24_t       video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;
    core_ctrl_t   core_controls;
    keys_t        player_2;
    dipsw_t       core_dipsw;
    logic         core_reset;

    integer       seed = 96;
    int           errors = 0;
    int           checks = 0;
    // adapter enable as last written over the bridge
    logic         ena_model;
    logic         check_ctrl;
    logic         check_video;

    // expected values, one pipeline slot per dut stage
    logic [31:0]  players_exp [2];
    logic [1:0]   ctrl_valid;
    rgb24_t       rgb_exp;
    logic         de_exp;
    logic         hs_exp;
    logic         vs_exp;
    logic         hs_last;
    logic         vs_last;
    logic         video_valid;

    starforce_shell starforce_shell_inst (.*);

    always #(CLK_PERIOD / 2) clk_74a = ~clk_74a;

    //////////////////////////////////////////////////////////////////////
    // reference models
    //////////////////////////////////////////////////////////////////////

    // difficulty 13:11, bonus 10:8, demo sounds 7, lives 5:4
    function automatic dipsw_t expected_dipsw(input lives_t lv, input difficulty_t df,
                                              input bonus_t bn, input logic demo);
        dipsw_t d;
        d        = '0;
        d[13:11] = df;
        d[10:8]  = bn;
        d[7]     = demo;
        d[5:4]   = lv;
        return d;
    endfunction

    // returns player 1 in the upper half, player 2 in the lower
    function automatic logic [31:0] expected_players(input logic ena, input cont_type_t ctype,
                                                     input assign_t mode,
                                                     input keys_t c1, input keys_t c2,
                                                     input keys_t b1, input keys_t b2,
                                                     input joy_t j1, input joy_t j2);
        keys_t       a1;
        keys_t       a2;
        logic [31:0] res;
        a1 = b1;
        a2 = b2;
        // analog pads: d-pad from the stick, y high byte, x low byte
        if (ctype == CONT_ANALOG_A || ctype == CONT_ANALOG_B) begin
            a1[KEY_UP]    = j1[15:8] < STICK_LOW;
            a1[KEY_DOWN]  = j1[15:8] > STICK_HIGH;
            a1[KEY_LEFT]  = j1[7:0] < STICK_LOW;
            a1[KEY_RIGHT] = j1[7:0] > STICK_HIGH;
            a2[KEY_UP]    = j2[15:8] < STICK_LOW;
            a2[KEY_DOWN]  = j2[15:8] > STICK_HIGH;
            a2[KEY_LEFT]  = j2[7:0] < STICK_LOW;
            a2[KEY_RIGHT] = j2[7:0] > STICK_HIGH;
        end
        if (!ena || ctype == CONT_NONE)
            res = {c1, c2};
        else if (mode == 2'd0)
            res = {a1, c1};
        else if (mode == 2'd1)
            res = {c1, b1};
        else if (mode == 2'd2)
            res = {a1, a2};
        else
            res = {a2, a1};
        return res;
    endfunction

    // core_controls without the coin bit
    function automatic logic [5:0] core_buttons(input keys_t p);
        return {p[KEY_UP], p[KEY_DOWN], p[KEY_LEFT], p[KEY_RIGHT], p[KEY_A], p[KEY_START]};
    endfunction

    function automatic rgb24_t expected_rgb(input rgb12_t rgb, input logic blanking,
                                            input logic black);
        rgb24_t c;
        c = '0;
        if (!blanking && !black) begin
            for (int i = 0; i < 3; i++) begin
                c[i*8 +: 4]     = rgb[i*4 +: 4];
                c[i*8 + 4 +: 4] = rgb[i*4 +: 4];
            end
        end
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("ERROR at %0t ns: %s expected %h actual %h", $time, name, exp_val, act_val);
        errors++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // expected value capture and compare
    //////////////////////////////////////////////////////////////////////

    // inputs are stable at the rising edge, same sample point as the dut
    always @(posedge clk_74a or negedge arst_n) begin
        if (!arst_n) begin
            players_exp[0] = '0;
            players_exp[1] = '0;
            ctrl_valid     = 2'b00;
            video_valid    = 1'b0;
            hs_last        = 1'b0;
            vs_last        = 1'b0;
        end else begin
            // router, two stages
            players_exp[1] = players_exp[0];
            players_exp[0] = expected_players(ena_model, snac_cont_type, snac_assignment,
                                              cont1_key, cont2_key, snac_p1_btn, snac_p2_btn,
                                              snac_p1_joy, snac_p2_joy);
            ctrl_valid     = {ctrl_valid[0], check_ctrl};
            // formatter, one stage
            rgb_exp     = expected_rgb(core_rgb, core_hblank || core_vblank,
                                       snac_blank_screen && ena_model);
            de_exp      = !(core_hblank || core_vblank);
            hs_exp      = core_hs && !hs_last;
            vs_exp      = core_vs && !vs_last;
            hs_last     = core_hs;
            vs_last     = core_vs;
            video_valid = check_video;
        end
    end

    always @(negedge clk_74a) begin
        if (ctrl_valid[1]) begin
            checks++;
            if (core_controls[6:1] !== core_buttons(players_exp[1][31:16]))
                report_mismatch("core_controls[6:1]", core_buttons(players_exp[1][31:16]),
                                core_controls[6:1]);
            if (player_2 !== players_exp[1][15:0])
                report_mismatch("player_2", players_exp[1][15:0], player_2);
        end
        if (video_valid) begin
            checks++;
            if (video_rgb !== rgb_exp)
                report_mismatch("video_rgb", rgb_exp, video_rgb);
            if (video_de !== de_exp)
                report_mismatch("video_de", de_exp, video_de);
            if (video_hs !== hs_exp)
                report_mismatch("video_hs", hs_exp, video_hs);
            if (video_vs !== vs_exp)
                report_mismatch("video_vs", vs_exp, video_vs);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers, all called at the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_74a);
    endtask

    // one-cycle write strobe
    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr      = 1'b0;
    endtask

    task automatic read_check(input bridge_addr_t addr, input bridge_data_t exp_val);
        bridge_addr = addr;
        @(negedge clk_74a);
        checks++;
        if (bridge_rd_data !== exp_val)
            report_mismatch("bridge_rd_data", exp_val, bridge_rd_data);
    endtask

    task automatic drive_random_controls;
        int pick;
        pick            = $random(seed) & 3;
        cont1_key       = keys_t'($random(seed));
        cont2_key       = keys_t'($random(seed));
        snac_p1_btn     = keys_t'($random(seed));
        snac_p2_btn     = keys_t'($random(seed));
        snac_p1_joy     = $random(seed);
        snac_p2_joy     = $random(seed);
        snac_assignment = assign_t'($random(seed));
        // bias toward the types that change the routing
        case (pick)
            0:       snac_cont_type = CONT_NONE;
            1:       snac_cont_type = CONT_ANALOG_A;
            2:       snac_cont_type = CONT_ANALOG_B;
            default: snac_cont_type = cont_type_t'($random(seed));
        endcase
    endtask

    task automatic drive_random_video;
        core_rgb          = rgb12_t'($random(seed));
        core_hblank       = ($random(seed) & 7) == 0;
        core_vblank       = ($random(seed) & 15) == 0;
        core_hs           = 1'($random(seed));
        core_vs           = 1'($random(seed));
        snac_blank_screen = 1'($random(seed));
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        bridge_data_t wdata;
        lives_t       lives_w;
        difficulty_t  diff_w;
        bonus_t       bonus_w;
        logic         demo_w;
        int           wait_cnt;
        int           len;
        arst_n            = 1'b0;
        bridge_addr       = '0;
        bridge_wr         = 1'b0;
        bridge_wr_data    = '0;
        cont1_key         = '0;
        cont2_key         = '0;
        snac_p1_btn       = '0;
        snac_p2_btn       = '0;
        snac_p1_joy       = '0;
        snac_p2_joy       = '0;
        snac_cont_type    = CONT_NONE;
        snac_assignment   = '0;
        snac_blank_screen = 1'b0;
        core_rgb          = '0;
        core_hblank       = 1'b0;
        core_vblank       = 1'b0;
        core_hs           = 1'b0;
        core_vs           = 1'b0;
        ena_model         = 1'b0;
        check_ctrl        = 1'b0;
        check_video       = 1'b0;
        wait_cycles(4);
        arst_n = 1'b1;

        // dip fields, random data with junk in the upper bits
        repeat (3) begin
            wdata   = $random(seed);
            lives_w = wdata[1:0];
            bridge_write(ADDR_LIVES, wdata);
            wdata   = $random(seed);
            diff_w  = wdata[2:0];
            bridge_write(ADDR_DIFFICULTY, wdata);
            wdata   = $random(seed);
            bonus_w = wdata[2:0];
            bridge_write(ADDR_BONUS, wdata);
            wdata   = $random(seed);
            demo_w  = wdata[0];
            bridge_write(ADDR_DEMO_SOUNDS, wdata);
            checks++;
            if (core_dipsw !== expected_dipsw(lives_w, diff_w, bonus_w, demo_w))
                report_mismatch("core_dipsw", expected_dipsw(lives_w, diff_w, bonus_w, demo_w),
                                core_dipsw);
        end

        // read-back
        bridge_write(ADDR_ADAPTER_ENA, 32'h0000_0001);
        read_check(ADDR_ADAPTER_ENA, 32'h0000_0001);
        // other addresses stay zero while the enable is set
        read_check(ADDR_LIVES, 32'h0000_0000);
        wdata = $random(seed);
        read_check(wdata, 32'h0000_0000);
        bridge_write(ADDR_ADAPTER_ENA, 32'hFFFF_FFFE);
        read_check(ADDR_ADAPTER_ENA, 32'h0000_0000);

        // manual reset
        bridge_write(ADDR_RESET_TOGGLE, 32'h0);
        wait_cnt = 0;
        while (!core_reset && wait_cnt < 4) begin
            @(negedge clk_74a);
            wait_cnt++;
        end
        checks++;
        if (!core_reset || wait_cnt > 2) begin
            $display("ERROR at %0t ns: core_reset did not rise within two cycles", $time);
            errors++;
        end
        // second toggle in the middle of the hold must be dropped
        len = 0;
        while (core_reset && len < RESET_HOLD_CYCLES + 8) begin
            bridge_wr = (len == 10);
            @(negedge clk_74a);
            len++;
        end
        bridge_wr = 1'b0;
        checks++;
        if (len < RESET_HOLD_CYCLES - 1 || len > RESET_HOLD_CYCLES + 1)
            report_mismatch("core_reset hold length", RESET_HOLD_CYCLES, len);
        wait_cycles(6);
        if (core_reset !== 1'b0) begin
            $display("ERROR at %0t ns: a toggle during the hold restarted core_reset", $time);
            errors++;
        end

        // routing, adapter off then on
        for (int phase = 0; phase < 2; phase++) begin
            bridge_write(ADDR_ADAPTER_ENA, bridge_data_t'(phase));
            ena_model = phase[0];
            wait_cycles(2);
            check_ctrl = 1'b1;
            repeat (CTRL_CYCLES / 2) begin
                drive_random_controls();
                @(negedge clk_74a);
            end
            check_ctrl = 1'b0;
            wait_cycles(3);
        end

        // coin, host pad 1 passes straight through with no adapter type
        snac_cont_type = CONT_NONE;
        cont1_key      = '0;
        cont2_key      = '0;
        snac_p1_btn    = '0;
        snac_p2_btn    = '0;
        wait_cycles(COIN_PULSE_CYCLES + 8);
        checks++;
        if (core_controls[0] !== 1'b0)
            report_mismatch("core_controls[0]", 0, core_controls[0]);
        cont1_key[KEY_SELECT] = 1'b1;
        wait_cycles(4);
        cont1_key[KEY_SELECT] = 1'b0;
        wait_cnt = 0;
        while (!core_controls[0] && wait_cnt < 8) begin
            @(negedge clk_74a);
            wait_cnt++;
        end
        if (!core_controls[0]) begin
            $display("ERROR at %0t ns: no coin pulse after the select release", $time);
            errors++;
        end
        len = 0;
        while (core_controls[0] && len < COIN_PULSE_CYCLES + 8) begin
            @(negedge clk_74a);
            len++;
        end
        checks++;
        if (len != COIN_PULSE_CYCLES)
            report_mismatch("coin pulse length", COIN_PULSE_CYCLES, len);

        // video, screen blanking only counts with the adapter on
        for (int phase = 0; phase < 2; phase++) begin
            bridge_write(ADDR_ADAPTER_ENA, bridge_data_t'(phase));
            ena_model = phase[0];
            wait_cycles(2);
            check_video = 1'b1;
            repeat (VIDEO_CYCLES / 2) begin
                drive_random_video();
                @(negedge clk_74a);
            end
            check_video = 1'b0;
            wait_cycles(2);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // hard stop in case a wait never ends
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the simulation ran past its time limit");
        $display("checks %0d, errors %0d", checks, errors);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
